// ==== logic/copper_bus_pkg.sv ====
//==========================================================================
// bus-side definitions for the slim copper
// covers the XR write bus, the copper program memory and the beam counters
// modules pull these in with a wildcard import in their header
//==========================================================================

package copper_bus_pkg;

    localparam int COPP_W = 11;             // program memory address width

    // XR bus words
    typedef logic [15:0] word_t;            // data word on XR bus and program memory
    typedef logic [15:0] xr_addr_t;         // [15:14] region, rest is offset

    // copper program memory
    typedef logic [COPP_W-1:0] copp_addr_t;

    // video beam position
    typedef logic [10:0] hres_t;            // horizontal count
    typedef logic [10:0] vres_t;            // vertical count

    // region code in xr_addr_t[15:14] for config registers
    // the copper pseudo registers live inside this region
    localparam logic [1:0] XR_REGION_CONFIG = 2'b00;

endpackage

// ==== logic/copper_isa_pkg.sv ====
//==========================================================================
// copper instruction set definitions
// opcode and state encodings, decode bit positions and the instruction
// word union that the control FSM decodes either as opcode or XR address
//==========================================================================

package copper_isa_pkg;

    // decode bit positions in an instruction word
    localparam int B_OPCODE  = 12;          // low bit of 2-bit opcode field
    localparam int B_HV_SEL  = 11;          // 0 = HPOS, 1 = VPOS
    localparam int B_BR_SEL  = 11;          // 0 = BRGE, 1 = BRLT
    localparam int B_COP_REG = 11;          // address targets copper RA register
    localparam int B_COP_SUB = 0;           // RA pseudo reg, 0 = load, 1 = subtract
    localparam int IM11_W    = 11;          // immediate / copper address operand width

    // opcodes, bit 13 clear means a two word instruction
    typedef enum logic [1:0] {
        OP_SETI  = 2'b00,                   // SETI xaddr,#im16
        OP_SETM  = 2'b01,                   // SETM xaddr,cadr11
        OP_HVPOS = 2'b10,                   // HPOS / VPOS #im11
        OP_BRCC  = 2'b11                    // BRGE / BRLT cadd11
    } copp_opcode_t;

    // execution state
    typedef enum logic [1:0] {
        ST_FETCH   = 2'b00,                 // fetch opcode, also stalls during HV wait
        ST_DECODE  = 2'b01,                 // decode / execute opcode in ir
        ST_SETM_RD = 2'b10,                 // SETM source read in flight
        ST_SETM_WR = 2'b11                  // SETM result goes out
    } copp_state_t;

    // instruction view of a word
    typedef struct packed {
        logic [1:0]        hi;              // region bits when word doubles as xaddr
        copp_opcode_t      opcode;
        logic              sel;             // HV select / branch select / cop reg
        logic [IM11_W-1:0] operand;         // im11 or copper address
    } copp_insn_t;

    // XR address view of the same word
    typedef struct packed {
        logic [1:0]        region;
        logic [1:0]        spare;
        logic              cop_reg;         // selects copper pseudo register
        logic [IM11_W-1:0] offset;
    } copp_xaddr_t;

    typedef union packed {
        copp_insn_t  insn;
        copp_xaddr_t xr;
    } copp_word_u;

endpackage

// ==== logic/copper_ra_if.sv ====
//==========================================================================
// link between copper control FSM and the accumulator datapath
// ctrl side issues a write pulse with data and load/subtract select,
// alu side returns RA and the borrow flag, no handshake involved
//==========================================================================

interface copper_ra_if import copper_bus_pkg::*; ();

    logic  reg_wr;                          // RA write pulse, RA updates on next edge
    logic  sub_sel;                         // 0 = load, 1 = subtract
    word_t wr_data;                         // last written data, also feeds compare
    word_t ra;                              // current accumulator
    logic  b_flag;                          // borrow of ra - wr_data

    modport ctrl (
        output reg_wr, sub_sel, wr_data,
        input  ra, b_flag
    );

    modport alu (
        input  reg_wr, sub_sel, wr_data,
        output ra, b_flag
    );

endinterface

// ==== logic/copper_ctrl.sv ====
//==========================================================================
// copper control
// holds enable/run flags and the frame-start restart, runs the
// fetch/decode/execute FSM and owns the XR write bus
// datapath blocks (PC, RA, beam wait) hang off the strobes driven here
//==========================================================================

module copper_ctrl import copper_bus_pkg::*, copper_isa_pkg::*; (
    input  logic       clk,
    input  logic       cop_reset,
    output logic       xr_wr_en_o,          // held until ack
    input  logic       xr_wr_ack_i,
    output xr_addr_t   xr_wr_addr_o,
    output word_t      xr_wr_data_o,
    input  word_t      copmem_rd_data_i,    // valid cycle after read enable
    input  logic       cop_xreg_wr_i,       // COPP_CTRL write strobe
    input  logic       cop_xreg_enable_i,
    input  logic       end_of_line_i,
    input  vres_t      v_count_i,
    copper_ra_if.ctrl  ra,
    input  logic       hv_waiting_i,
    output logic       copp_rst_o,          // internal copper reset level
    output logic       rd_en_o,             // request program memory read
    output logic       pc_inc_o,
    output logic       pc_load_o,           // take branch
    output logic       rd_src_sel_o,        // read SETM source instead of PC
    output copp_addr_t src_addr_o,          // branch target / SETM source / HV pos
    output logic       hv_start_o,
    output logic       hv_sel_o
);

    copp_state_t state;
    copp_word_u  ir;                        // instruction register
    logic        cop_en;                    // set by COPP_CTRL
    logic        cop_run;                   // running this frame
    logic        rd_q;                      // read enable now at memory
    logic        rd_pipe;                   // read data valid this cycle
    logic        rd_reg_save;               // SETM source is RA
    logic        dest_is_ra;                // ir address hits RA pseudo reg

    assign dest_is_ra = (ir.xr.region == XR_REGION_CONFIG) && ir.xr.cop_reg;
    assign src_addr_o = ir.xr.offset;       // low 11 bits double as copper address
    assign hv_sel_o   = ir[B_HV_SEL];

    assign ra.wr_data = xr_wr_data_o;       // RA shares the XR data register
    assign ra.sub_sel = xr_wr_addr_o[B_COP_SUB];

    // enable strobe plus restart at end of line 0
    always_ff @(posedge clk) begin
        if (cop_reset) begin
            cop_en     <= 1'b0;
            cop_run    <= 1'b0;
            copp_rst_o <= 1'b1;
        end else begin
            if (end_of_line_i && (v_count_i == '0)) begin
                copp_rst_o <= 1'b1;         // new frame, restart from address 0
                cop_run    <= cop_en;
            end else begin
                copp_rst_o <= !cop_run;     // hold in reset while stopped
            end
            if (cop_xreg_wr_i) begin
                cop_en <= cop_xreg_enable_i;
                if (!cop_xreg_enable_i) begin
                    cop_run <= 1'b0;        // disable stops right away
                end
            end
        end
    end

    // strobes to PC and beam wait
    always_comb begin
        rd_en_o      = 1'b0;
        pc_inc_o     = 1'b0;
        pc_load_o    = 1'b0;
        rd_src_sel_o = 1'b0;
        hv_start_o   = 1'b0;
        case (state)
            ST_FETCH: begin
                if (!rd_pipe) begin
                    if (!hv_waiting_i && !rd_q) begin   // start opcode read
                        rd_en_o  = 1'b1;
                        pc_inc_o = 1'b1;
                    end
                end else if (!copmem_rd_data_i[B_OPCODE+1]) begin
                    rd_en_o  = 1'b1;        // two word op, read 2nd word now
                    pc_inc_o = 1'b1;
                end
            end
            ST_DECODE: begin
                case (ir.insn.opcode)
                    OP_SETI: begin
                        rd_en_o  = rd_pipe; // prefetch next opcode with the write
                        pc_inc_o = rd_pipe;
                    end
                    OP_SETM: begin
                        rd_en_o      = 1'b1;
                        rd_src_sel_o = 1'b1;
                    end
                    OP_HVPOS: hv_start_o = 1'b1;
                    OP_BRCC:  pc_load_o  = (ra.b_flag == ir[B_BR_SEL]);
                endcase
            end
            ST_SETM_RD: rd_en_o  = 1'b1;    // next opcode read overlaps the write
            ST_SETM_WR: pc_inc_o = 1'b1;
        endcase
    end

    // main FSM, XR write bus and RA write pulse
    always_ff @(posedge clk) begin
        if (copp_rst_o) begin
            state        <= ST_FETCH;
            ir           <= '0;
            rd_q         <= 1'b0;
            rd_pipe      <= 1'b0;
            rd_reg_save  <= 1'b0;
            ra.reg_wr    <= 1'b0;
            xr_wr_en_o   <= 1'b0;
            xr_wr_addr_o <= '0;
            xr_wr_data_o <= '0;
        end else begin
            rd_q      <= rd_en_o;
            rd_pipe   <= rd_q;
            ra.reg_wr <= 1'b0;              // one cycle pulse
            if (xr_wr_ack_i) begin
                xr_wr_en_o <= 1'b0;
            end
            case (state)
                ST_FETCH: begin
                    if (rd_pipe) begin
                        ir    <= copmem_rd_data_i;
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    case (ir.insn.opcode)
                        OP_SETI: begin
                            if (rd_pipe) begin      // immediate word arrived
                                xr_wr_addr_o <= ir;
                                xr_wr_data_o <= copmem_rd_data_i;
                                if (dest_is_ra) begin
                                    ra.reg_wr <= 1'b1;
                                end else begin
                                    xr_wr_en_o <= 1'b1;
                                end
                                state <= ST_FETCH;
                            end
                        end
                        OP_SETM: begin
                            rd_reg_save <= ir[B_COP_REG];
                            state       <= ST_SETM_RD;
                        end
                        OP_HVPOS: state <= ST_FETCH;
                        OP_BRCC:  state <= ST_FETCH;
                    endcase
                end
                ST_SETM_RD: begin
                    ir    <= copmem_rd_data_i;      // dest address word
                    state <= ST_SETM_WR;
                end
                ST_SETM_WR: begin
                    xr_wr_addr_o <= ir;
                    xr_wr_data_o <= rd_reg_save ? ra.ra : copmem_rd_data_i;
                    if (dest_is_ra) begin
                        ra.reg_wr <= 1'b1;
                    end else begin
                        xr_wr_en_o <= 1'b1;
                    end
                    state <= ST_FETCH;
                end
            endcase
        end
    end

endmodule

// ==== logic/copper_pc.sv ====
//==========================================================================
// copper program counter and program memory read port
// PC steps on inc, loads on a taken branch; the read address register
// picks the PC, the branch target or a SETM source address
//==========================================================================

module copper_pc import copper_bus_pkg::*; (
    input  logic       clk,
    input  logic       copp_rst_i,
    input  logic       inc_i,               // step PC
    input  logic       load_i,              // branch taken
    input  logic       src_sel_i,           // SETM source read
    input  copp_addr_t target_i,
    input  copp_addr_t src_addr_i,
    input  logic       rd_en_i,
    output copp_addr_t copmem_rd_addr_o,
    output logic       copmem_rd_en_o
);

    copp_addr_t pc;

    always_ff @(posedge clk) begin
        if (copp_rst_i) begin
            pc               <= '0;
            copmem_rd_addr_o <= '0;
            copmem_rd_en_o   <= 1'b0;
        end else begin
            copmem_rd_en_o <= rd_en_i;
            if (load_i) begin
                pc <= target_i;
            end else if (inc_i) begin
                pc <= pc + 1'b1;
            end
            // address follows old PC unless redirected
            if (src_sel_i) begin
                copmem_rd_addr_o <= src_addr_i;
            end else if (load_i) begin
                copmem_rd_addr_o <= target_i;
            end else begin
                copmem_rd_addr_o <= pc;
            end
        end
    end

endmodule

// ==== logic/copper_ra_alu.sv ====
//==========================================================================
// copper accumulator RA with borrow flag
// 17-bit unsigned subtract of the written data from RA, the carry out is B
// a write pulse loads RA with the data or with the difference
//==========================================================================

module copper_ra_alu import copper_bus_pkg::*; (
    input  logic     clk,
    input  logic     copp_rst_i,
    copper_ra_if.alu ra
);

    word_t ra_q;
    word_t diff;                            // ra - wr_data
    logic  borrow;

    assign {borrow, diff} = {1'b0, ra_q} - {1'b0, ra.wr_data};

    assign ra.ra     = ra_q;
    assign ra.b_flag = borrow;              // follows every write, load leaves 0

    always_ff @(posedge clk) begin
        if (copp_rst_i) begin
            ra_q <= '0;
        end else if (ra.reg_wr) begin
            ra_q <= ra.sub_sel ? diff : ra.wr_data;
        end
    end

endmodule

// ==== logic/copper_beam_wait.sv ====
//==========================================================================
// HPOS / VPOS wait
// start latches the target position and the H/V choice; the wait flag
// drops once the selected beam count is at or past that position
//==========================================================================

module copper_beam_wait import copper_bus_pkg::*; (
    input  logic  clk,
    input  logic  copp_rst_i,
    input  logic  start_i,                  // HVPOS decoded
    input  logic  v_sel_i,                  // 1 = VPOS
    input  hres_t pos_i,                    // im11 operand
    input  hres_t h_count_i,
    input  vres_t v_count_i,
    output logic  hv_waiting_o
);

    hres_t pos_q;
    logic  v_sel_q;
    logic  reached;

    assign reached = v_sel_q ? (v_count_i >= pos_q) : (h_count_i >= pos_q);

    // compare position of the current wait
    always_ff @(posedge clk) begin
        if (start_i) begin
            pos_q <= pos_i;
        end
    end

    always_ff @(posedge clk) begin
        if (copp_rst_i) begin
            hv_waiting_o <= 1'b0;
            v_sel_q      <= 1'b0;
        end else if (start_i) begin
            hv_waiting_o <= 1'b1;
            v_sel_q      <= v_sel_i;
        end else if (hv_waiting_o && reached) begin
            hv_waiting_o <= 1'b0;           // release so fetch resumes next cycle
        end
    end

endmodule

// ==== logic/copper_top.sv ====
//==========================================================================
// slim display copper top level
// runs a program from external copper memory in step with the beam and
// writes XR registers; plain ports toward the video block and memory
//==========================================================================

module copper_top import copper_bus_pkg::*; (
    input  logic       clk,
    input  logic       cop_reset,
    output logic       xr_wr_en_o,
    input  logic       xr_wr_ack_i,
    output xr_addr_t   xr_wr_addr_o,
    output word_t      xr_wr_data_o,
    output copp_addr_t copmem_rd_addr_o,
    output logic       copmem_rd_en_o,
    input  word_t      copmem_rd_data_i,
    input  logic       cop_xreg_wr_i,
    input  logic       cop_xreg_enable_i,
    input  hres_t      h_count_i,
    input  vres_t      v_count_i,
    input  logic       end_of_line_i
);

    logic       copp_rst;                   // copper held / restarted
    logic       rd_en;
    logic       pc_inc;
    logic       pc_load;
    logic       rd_src_sel;
    copp_addr_t src_addr;                   // shared operand field of ir
    logic       hv_start;
    logic       hv_sel;
    logic       hv_waiting;

    copper_ra_if ra_bus ();

    copper_ctrl u_ctrl (
        .clk               (clk),
        .cop_reset         (cop_reset),
        .xr_wr_en_o        (xr_wr_en_o),
        .xr_wr_ack_i       (xr_wr_ack_i),
        .xr_wr_addr_o      (xr_wr_addr_o),
        .xr_wr_data_o      (xr_wr_data_o),
        .copmem_rd_data_i  (copmem_rd_data_i),
        .cop_xreg_wr_i     (cop_xreg_wr_i),
        .cop_xreg_enable_i (cop_xreg_enable_i),
        .end_of_line_i     (end_of_line_i),
        .v_count_i         (v_count_i),
        .ra                (ra_bus.ctrl),
        .hv_waiting_i      (hv_waiting),
        .copp_rst_o        (copp_rst),
        .rd_en_o           (rd_en),
        .pc_inc_o          (pc_inc),
        .pc_load_o         (pc_load),
        .rd_src_sel_o      (rd_src_sel),
        .src_addr_o        (src_addr),
        .hv_start_o        (hv_start),
        .hv_sel_o          (hv_sel)
    );

    copper_pc u_pc (
        .clk              (clk),
        .copp_rst_i       (copp_rst),
        .inc_i            (pc_inc),
        .load_i           (pc_load),
        .src_sel_i        (rd_src_sel),
        .target_i         (src_addr),       // branch address field
        .src_addr_i       (src_addr),       // SETM source field
        .rd_en_i          (rd_en),
        .copmem_rd_addr_o (copmem_rd_addr_o),
        .copmem_rd_en_o   (copmem_rd_en_o)
    );

    copper_ra_alu u_ra_alu (
        .clk        (clk),
        .copp_rst_i (copp_rst),
        .ra         (ra_bus.alu)
    );

    copper_beam_wait u_beam_wait (
        .clk          (clk),
        .copp_rst_i   (copp_rst),
        .start_i      (hv_start),
        .v_sel_i      (hv_sel),
        .pos_i        (src_addr),           // im11 position field
        .h_count_i    (h_count_i),
        .v_count_i    (v_count_i),
        .hv_waiting_o (hv_waiting)
    );

endmodule

// ==== testbench/tb_copper_programs.svh ====
//==========================================================================
// copper test program and the XR writes it must produce
// included inside the testbench module, fills the program memory and
// the expected write queues before reset is released
//==========================================================================

`ifndef TB_COPPER_PROGRAMS_SVH
`define TB_COPPER_PROGRAMS_SVH

localparam logic [15:0] RA_LOAD = 16'h0800;     // config region RA register in load form
localparam logic [15:0] RA_SUB  = 16'h0801;     // same register in subtract form

logic [15:0] exp_addr [$];
logic [15:0] exp_data [$];
logic [10:0] exp_min_v [$];                     // earliest line for this write
logic [10:0] exp_min_h [$];                     // earliest pixel for this write
logic [10:0] pa;                                // program assembly pointer

// unsigned a - b borrows when a is below b
function automatic logic sub_borrow(input logic [15:0] a, input logic [15:0] b);
    return (a < b);
endfunction

task automatic emit_word(input logic [15:0] w);
    mem[pa] = w;
    pa = pa + 1'b1;
endtask

task automatic put_seti(input logic [15:0] xa, input logic [15:0] im);
    emit_word(xa);                              // address word doubles as opcode
    emit_word(im);
endtask

task automatic put_setm(input logic [15:0] xa, input logic [10:0] src, input logic from_ra);
    emit_word({2'b00, 2'b01, from_ra, src});
    emit_word(xa);
endtask

task automatic put_hvpos(input logic vert, input logic [10:0] pos);
    emit_word({2'b00, 2'b10, vert, pos});
endtask

task automatic put_branch(input logic lt, input logic [10:0] target);
    emit_word({2'b00, 2'b11, lt, target});
endtask

task automatic expect_write(input logic [15:0] a, input logic [15:0] d,
                            input logic [10:0] min_v, input logic [10:0] min_h);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_min_v.push_back(min_v);
    exp_min_h.push_back(min_h);
endtask

task automatic build_program();
    for (int a = 0; a < 2048; a++) begin
        mem[a] = {5'b00101, 11'(a)};            // unused words decode as VPOS a
    end
    mem[11'h400] = 16'h5A5A;                    // SETM table
    mem[11'h401] = 16'hC3C3;
    pa = '0;
    put_seti(16'h4010, 16'h1234);
    expect_write(16'h4010, 16'h1234, 0, 0);
    put_seti(16'h8123, 16'hABCD);
    expect_write(16'h8123, 16'hABCD, 0, 0);
    put_seti(16'h0020, 16'h0F0F);
    expect_write(16'h0020, 16'h0F0F, 0, 0);
    put_setm(16'h4020, 11'h400, 1'b0);
    expect_write(16'h4020, 16'h5A5A, 0, 0);
    put_seti(RA_LOAD, 16'h0020);                // RA = 0x20 with no bus write
    put_setm(16'h4030, 11'h000, 1'b1);
    expect_write(16'h4030, 16'h0020, 0, 0);
    put_seti(RA_SUB, 16'h0003);                 // at 12
    put_branch(1'b1, 11'd18);                   // BRLT to the 40E1 marker
    put_branch(1'b0, 11'd20);                   // BRGE past both markers
    put_seti(16'h40E0, 16'hDEAD);               // never reached
    put_seti(16'h40E1, 16'hBEEF);               // at 18 on the borrow path only
    if (sub_borrow(16'h0020, 16'h0003)) begin
        expect_write(16'h40E1, 16'hBEEF, 0, 0);
    end
    put_setm(16'h4031, 11'h000, 1'b1);          // at 20
    expect_write(16'h4031, 16'h001D, 0, 0);     // 0x20 minus 0x03
    put_seti(RA_LOAD, 16'h0005);
    put_seti(RA_SUB, 16'h9000);                 // at 24 and wraps below zero
    put_branch(1'b0, 11'd30);                   // BRGE to the 40E3 marker
    put_branch(1'b1, 11'd32);                   // BRLT past both markers
    put_seti(16'h40E2, 16'hDEAD);
    put_seti(16'h40E3, 16'hBEEF);               // at 30 on the no borrow path only
    if (!sub_borrow(16'h0005, 16'h9000)) begin
        expect_write(16'h40E3, 16'hBEEF, 0, 0);
    end
    put_setm(16'h4032, 11'h000, 1'b1);          // at 32
    expect_write(16'h4032, 16'h7005, 0, 0);     // 0x0005 minus 0x9000 wrapped
    put_hvpos(1'b1, 11'd100);
    put_seti(16'h4050, 16'h0064);
    expect_write(16'h4050, 16'h0064, 100, 0);
    put_hvpos(1'b0, 11'd400);
    put_seti(16'h4051, 16'h0190);
    expect_write(16'h4051, 16'h0190, 100, 400);
    put_setm(16'h4052, 11'h401, 1'b0);
    expect_write(16'h4052, 16'hC3C3, 100, 400);
    put_hvpos(1'b1, 11'd2047);                  // park until the next frame
endtask

`endif

// ==== testbench/tb_copper_top.sv ====
//==========================================================================
// testbench for the slim copper
// program memory and XR ack models plus free running beam counters;
// enables the copper, checks two full frames of writes, then disables it
//==========================================================================

module tb_copper_top import copper_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam hres_t H_LAST = 11'd799;         // 800 pixels per line
    localparam vres_t V_LAST = 11'd524;         // 525 lines per frame
    localparam int    TIMEOUT_CYCLES = 6 * 800 * 525;

    logic       clk = 1'b0;
    logic       cop_reset;
    logic       cop_xreg_wr;
    logic       cop_xreg_enable;
    logic       xr_wr_en, copmem_rd_en, end_of_line;
    logic       xr_wr_ack = 1'b0;
    xr_addr_t   xr_wr_addr;
    word_t      xr_wr_data;
    copp_addr_t copmem_rd_addr;
    word_t      copmem_rd_data = '0;
    hres_t      h_count = '0;
    vres_t      v_count = '0;
    word_t      mem [0:2047];

    int          errors = 0;
    int          writes_seen = 0;
    int          frames_checked = 0;
    int          exp_idx = 0;
    int          cycles = 0;
    int unsigned ack_left = 0;                  // cycles to ack of current write
    int          off_cycles = 0;                // cycles since copper stopped
    logic        armed = 1'b0, live = 1'b0;     // expected enable and run state
    logic        en_q = 1'b0, ack_q = 1'b0;
    xr_addr_t    addr_q;
    word_t       data_q;

    `include "tb_copper_programs.svh"

    copper_top dut_i (
        .clk (clk), .cop_reset (cop_reset),
        .xr_wr_en_o (xr_wr_en), .xr_wr_ack_i (xr_wr_ack),
        .xr_wr_addr_o (xr_wr_addr), .xr_wr_data_o (xr_wr_data),
        .copmem_rd_addr_o (copmem_rd_addr), .copmem_rd_en_o (copmem_rd_en),
        .copmem_rd_data_i (copmem_rd_data),
        .cop_xreg_wr_i (cop_xreg_wr), .cop_xreg_enable_i (cop_xreg_enable),
        .h_count_i (h_count), .v_count_i (v_count), .end_of_line_i (end_of_line)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (copmem_rd_en) begin
            copmem_rd_data <= mem[copmem_rd_addr];  // valid the cycle after
        end
    end

    assign end_of_line = (h_count == H_LAST);
    always @(posedge clk) begin
        if (end_of_line) begin
            h_count <= '0;
            v_count <= (v_count == V_LAST) ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // one cycle ack pulse 1 or 2 cycles after a write is seen
    always @(posedge clk) begin
        if (cop_reset || !xr_wr_en) begin
            xr_wr_ack <= 1'b0;
            ack_left = 0;
        end else if (xr_wr_ack) begin
            xr_wr_ack <= 1'b0;
        end else begin
            if (ack_left == 0) ack_left = 1 + ($urandom % 2);
            ack_left = ack_left - 1;
            if (ack_left == 0) xr_wr_ack <= 1'b1;
        end
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    task automatic check_write();
        writes_seen++;
        assert (exp_idx < exp_addr.size())
            else flag_error($sformatf("extra XR write %h <= %h", xr_wr_addr, xr_wr_data));
        if (exp_idx < exp_addr.size()) begin
            assert (xr_wr_addr == exp_addr[exp_idx] && xr_wr_data == exp_data[exp_idx])
                else flag_error($sformatf("write %0d is %h <= %h, expected %h <= %h",
                    exp_idx, xr_wr_addr, xr_wr_data, exp_addr[exp_idx], exp_data[exp_idx]));
            assert (v_count >= exp_min_v[exp_idx] && h_count >= exp_min_h[exp_idx])
                else flag_error($sformatf("write %0d early at line %0d pixel %0d",
                    exp_idx, v_count, h_count));
            exp_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (!cop_reset) begin
            en_q       <= xr_wr_en;
            ack_q      <= xr_wr_ack;
            addr_q     <= xr_wr_addr;
            data_q     <= xr_wr_data;
            off_cycles <= live ? 0 : off_cycles + 1;
            if (off_cycles >= 4) begin          // past the stop latency
                assert (!copmem_rd_en && !xr_wr_en)
                    else flag_error("memory read or XR write while copper is stopped");
            end
            if (en_q && !ack_q) begin           // unacked write must hold
                assert (xr_wr_en && xr_wr_addr == addr_q && xr_wr_data == data_q)
                    else flag_error("XR write dropped or changed before its ack");
            end
            if (xr_wr_en && !en_q) check_write();
            if (end_of_line && v_count == '0) begin     // frame restart
                if (live) begin
                    assert (exp_idx == exp_addr.size())
                        else flag_error($sformatf("frame ended after %0d of %0d writes",
                            exp_idx, exp_addr.size()));
                    frames_checked++;
                end
                exp_idx = 0;
                live <= armed;
            end
            if (cop_xreg_wr) begin
                armed <= cop_xreg_enable;
                if (!cop_xreg_enable) live <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic set_enable(input logic en);
        @(posedge clk);
        cop_xreg_wr     <= 1'b1;
        cop_xreg_enable <= en;
        @(posedge clk);
        cop_xreg_wr     <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h46563201));
        cop_reset       = 1'b1;
        cop_xreg_wr     = 1'b0;
        cop_xreg_enable = 1'b0;
        build_program();
        repeat (5) @(posedge clk);
        cop_reset <= 1'b0;
        repeat (1000) @(posedge clk);           // stopped copper stays silent
        set_enable(1'b1);                       // arms and runs from next frame
        while (frames_checked < 2) @(posedge clk);
        while (v_count != 11'd300) @(posedge clk);  // program parked on VPOS
        set_enable(1'b0);
        while (!(end_of_line && v_count == '0)) @(posedge clk);
        repeat (1000) @(posedge clk);           // no restart once disabled
        $display("done: %0d writes, %0d frames checked, %0d errors",
                 writes_seen, frames_checked, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+testbench
logic/copper_bus_pkg.sv
logic/copper_isa_pkg.sv
logic/copper_ra_if.sv
logic/copper_ctrl.sv
logic/copper_pc.sv
logic/copper_ra_alu.sv
logic/copper_beam_wait.sv
logic/copper_top.sv
testbench/tb_copper_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the copper testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_copper_top -Mdir obj_dir -o sim_copper
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_copper > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
